// ==== verification/hdgen_testdata.txt ====
0 0 0 1
1 0 0 2
3 0 0 4
7 0 0 8
2 25 0 3
5 25 0 6
10 25 0 11
4 50 0 5
9 50 0 10
15 50 0 16
6 75 0 7
12 75 0 13
20 10 0 21
0 60 0 1
31 30 0 32
8 90 0 9
3 0 0 4
16 40 0 17
1 80 0 2
5 0 0 6

// ==== project.f ====
verilog/hdgen_pkg.sv
verilog/vec_stream_if.sv
verilog/axil_regs.sv
verilog/xorshift32.sv
verilog/item_vector_gen.sv
verilog/axis_vec_out.sv
verilog/hdgen_top.sv
verification/tb_hdgen_top.sv

// ==== Bender.yml ====
package:
  name: hdgen

sources:
  - files:
      - verilog/hdgen_pkg.sv
      - verilog/vec_stream_if.sv
      - verilog/axil_regs.sv
      - verilog/xorshift32.sv
      - verilog/item_vector_gen.sv
      - verilog/axis_vec_out.sv
      - verilog/hdgen_top.sv
  - target: test
    files:
      - verification/tb_hdgen_top.sv

// ==== verification/tb_hdgen_top.sv ====
`timescale 1ns/1ps

module tb_hdgen_top import hdgen_pkg::*; ();

    localparam int DIM   = 128;
    localparam int WORDS = DIM / 32;

    logic           AXIS_ACLK;
    logic           S_AXI_ARESETN;
    axil_addr_t     s_axi_awaddr;
    logic           s_axi_awvalid;
    logic           s_axi_awready;
    axil_data_t     s_axi_wdata;
    logic [3:0]     s_axi_wstrb;
    logic           s_axi_wvalid;
    logic           s_axi_wready;
    logic [1:0]     s_axi_bresp;
    logic           s_axi_bvalid;
    logic           s_axi_bready;
    axil_addr_t     s_axi_araddr;
    logic           s_axi_arvalid;
    logic           s_axi_arready;
    axil_data_t     s_axi_rdata;
    logic [1:0]     s_axi_rresp;
    logic           s_axi_rvalid;
    logic           s_axi_rready;
    logic           m_axis_tvalid;
    logic [DIM-1:0] m_axis_tdata;
    logic           m_axis_tlast;
    logic           m_axis_tready;

    // test table from the data file
    int             t_count[$];
    int             t_stall[$];
    int             t_gen[$];
    int             t_done[$];
    int             fd;
    int             i;
    int             a;
    int             b;
    int             c;
    int             d;
    int             budget;
    int             limit_cycles = 0;
    int             seed = 28;
    axil_data_t     rd_val;

    // sink and reference model state
    logic           sink_on = 1'b0;
    int             stall_pct = 0;
    int             cur_count = 0;
    int             beat_cnt = 0;
    int             wi;
    word_t          model_state;
    logic [DIM-1:0] exp_vec;
    logic           prev_stall = 1'b0;
    logic [DIM-1:0] prev_data;

    hdgen_top #(.DIM(DIM)) uut (.*);

    always #2 AXIS_ACLK = ~AXIS_ACLK;

    function automatic word_t xs_step(input word_t s);
        word_t t;
        t = s ^ (s << xs_shift_a);
        t = t ^ (t >> xs_shift_b);
        t = t ^ (t << xs_shift_c);
        return t;
    endfunction

    task automatic check(input string name, input logic [DIM-1:0] got,
                         input logic [DIM-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    // ========================================================================
    // AXI-Lite master, called right after a rising edge
    // ========================================================================

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wstrb   <= 4'hf;
        s_axi_wvalid  <= 1'b1;
        s_axi_bready  <= 1'b1;
        do begin
            @(posedge AXIS_ACLK);
            if (s_axi_awvalid && s_axi_awready) begin
                s_axi_awvalid <= 1'b0;
            end
            if (s_axi_wvalid && s_axi_wready) begin
                s_axi_wvalid <= 1'b0;
            end
        end while (!(s_axi_bvalid && s_axi_bready));
        check("s_axi_bresp", s_axi_bresp, 0);
        s_axi_bready <= 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        s_axi_rready  <= 1'b1;
        do begin
            @(posedge AXIS_ACLK);
            if (s_axi_arvalid && s_axi_arready) begin
                s_axi_arvalid <= 1'b0;
            end
        end while (!(s_axi_rvalid && s_axi_rready));
        data = s_axi_rdata;
        check("s_axi_rresp", s_axi_rresp, 0);
        s_axi_rready <= 1'b0;
    endtask

    // random back-pressure
    always @(posedge AXIS_ACLK) begin
        m_axis_tready <= sink_on && (({$random(seed)} % 100) >= stall_pct);
    end

    // stream monitor against the xorshift model
    always @(posedge AXIS_ACLK) begin
        if (S_AXI_ARESETN && prev_stall && m_axis_tvalid) begin
            check("m_axis_tdata while stalled", m_axis_tdata, prev_data);
        end
        if (S_AXI_ARESETN && m_axis_tvalid && m_axis_tready) begin
            check("beat within run", beat_cnt <= cur_count, 1);
            for (wi = 0; wi < WORDS; wi++) begin
                model_state = xs_step(model_state);
                exp_vec[wi*32 +: 32] = model_state;
            end
            check("m_axis_tdata", m_axis_tdata, exp_vec);
            check("m_axis_tlast", m_axis_tlast, beat_cnt == cur_count);
            beat_cnt = beat_cnt + 1;
        end
        prev_stall = m_axis_tvalid && !m_axis_tready;
        prev_data  = m_axis_tdata;
    end

    // watchdog, armed once the test table is known
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge AXIS_ACLK);
        $display("Run timed out after %0d cycles without finishing", limit_cycles);
        $display("Verification failed");
        $fatal(1, "timeout");
    end

    initial begin
        AXIS_ACLK     = 1'b0;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = 4'h0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        m_axis_tready = 1'b0;

        fd = $fopen("verification/hdgen_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            $display("Verification failed");
            $fatal(1, "missing test data");
        end
        while ($fscanf(fd, "%d %d %d %d\n", a, b, c, d) == 4) begin
            t_count.push_back(a);
            t_stall.push_back(b);
            t_gen.push_back(c);
            t_done.push_back(d);
        end
        $fclose(fd);
        if (t_count.size() == 0) begin
            $display("The test data file holds no tests");
            $display("Verification failed");
            $fatal(1, "empty test data");
        end
        budget = 1000;
        for (i = 0; i < t_count.size(); i++) begin
            budget += (t_count[i] + 1) * WORDS * 20 + 200;
        end
        limit_cycles = budget;

        repeat (10) @(posedge AXIS_ACLK);
        S_AXI_ARESETN <= 1'b1;

        // register access and abort with the stream stalled
        axil_write(reg_count_off, 32'd3);
        axil_read(reg_count_off, rd_val);
        check("count register", rd_val, 3);
        axil_write(reg_ctrl_off, 32'd1);
        axil_read(reg_ctrl_off, rd_val);
        check("ctrl register", rd_val, 1);
        axil_read(32'h0000_000c, rd_val);
        check("unmapped register", rd_val, 0);
        axil_write(reg_ctrl_off, 32'd0);
        axil_read(reg_ctrl_off, rd_val);
        check("ctrl register after abort", rd_val, 0);
        axil_read(reg_done_off, rd_val);
        check("done register after abort", rd_val, 0);

        // each run starts from the seed
        for (i = 0; i < t_count.size(); i++) begin
            cur_count   = t_count[i];
            stall_pct   = t_stall[i];
            beat_cnt    = 0;
            model_state = xs_seed;
            axil_write(reg_count_off, t_count[i]);
            axil_read(reg_count_off, rd_val);
            check("count register", rd_val, t_count[i]);
            sink_on <= 1'b1;
            axil_write(reg_ctrl_off, 32'd1);
            wait (beat_cnt == t_count[i] + 1);
            sink_on <= 1'b0;
            axil_read(reg_ctrl_off, rd_val);
            check("ctrl register after run", rd_val, t_gen[i]);
            axil_read(reg_done_off, rd_val);
            check("done register", rd_val, t_done[i]);
            // nothing more offered once the run has ended
            check("m_axis_tvalid after run", m_axis_tvalid, 0);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== verilog/hdgen_top.sv ====
`timescale 1ns/1ps

module hdgen_top import hdgen_pkg::*; #(
    parameter int DIM = 128
) (
    input  logic           AXIS_ACLK,
    input  logic           S_AXI_ARESETN,
    // AXI-Lite slave
    input  axil_addr_t     s_axi_awaddr,
    input  logic           s_axi_awvalid,
    output logic           s_axi_awready,
    input  axil_data_t     s_axi_wdata,
    input  logic [3:0]     s_axi_wstrb,
    input  logic           s_axi_wvalid,
    output logic           s_axi_wready,
    output logic [1:0]     s_axi_bresp,
    output logic           s_axi_bvalid,
    input  logic           s_axi_bready,
    input  axil_addr_t     s_axi_araddr,
    input  logic           s_axi_arvalid,
    output logic           s_axi_arready,
    output axil_data_t     s_axi_rdata,
    output logic [1:0]     s_axi_rresp,
    output logic           s_axi_rvalid,
    input  logic           s_axi_rready,
    // AXI-Stream master
    output logic           m_axis_tvalid,
    output logic [DIM-1:0] m_axis_tdata,
    output logic           m_axis_tlast,
    input  logic           m_axis_tready
);

    logic      gen;
    item_cnt_t item_count;
    logic      done_pulse;
    item_cnt_t done_count;

    vec_stream_if #(.DIM(DIM)) vec_if ();

    axil_regs u_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .gen           (gen),
        .item_count    (item_count),
        .done_pulse    (done_pulse),
        .done_count    (done_count)
    );

    item_vector_gen #(.DIM(DIM)) u_gen (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .item_count    (item_count),
        .vs            (vec_if.producer)
    );

    axis_vec_out #(.DIM(DIM)) u_out (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .vs            (vec_if.consumer),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready),
        .done_pulse    (done_pulse),
        .done_count    (done_count)
    );

endmodule

// ==== verilog/axis_vec_out.sv ====
`timescale 1ns/1ps

module axis_vec_out import hdgen_pkg::*; #(
    parameter int DIM = 128
) (
    input  logic           AXIS_ACLK,
    input  logic           S_AXI_ARESETN,
    input  logic           gen,
    vec_stream_if.consumer vs,
    output logic           m_axis_tvalid,
    output logic [DIM-1:0] m_axis_tdata,
    output logic           m_axis_tlast,
    input  logic           m_axis_tready,
    output logic           done_pulse,
    output item_cnt_t      done_count
);

    // two entry FIFO
    logic [DIM-1:0] buf_data  [2];
    logic           buf_last  [2];
    item_cnt_t      buf_index [2];
    logic           wr_ptr;
    logic           rd_ptr;
    logic [1:0]     count;
    logic           push;
    logic           pop;
    logic           gen_q;

    assign vs.ready = (count != 2'd2);
    assign push     = vs.valid && vs.ready;
    assign pop      = m_axis_tvalid && m_axis_tready;

    always_ff @(posedge AXIS_ACLK) begin
        if (push) begin
            buf_data[wr_ptr]  <= vs.data;
            buf_last[wr_ptr]  <= vs.last;
            buf_index[wr_ptr] <= vs.index;
        end
    end

    // flushed whenever gen is low
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    assign m_axis_tvalid = (count != 2'd0);
    assign m_axis_tdata  = buf_data[rd_ptr];
    assign m_axis_tlast  = buf_last[rd_ptr];
    assign done_pulse    = pop && buf_last[rd_ptr];

    // ========================================================================
    // completion count, kept after gen clears
    // ========================================================================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen_q      <= 1'b0;
            done_count <= '0;
        end else begin
            gen_q <= gen;
            if (gen && !gen_q) begin
                done_count <= '0;
            end else if (pop) begin
                // vectors leave in index order
                done_count <= buf_index[rd_ptr] + 1'b1;
            end
        end
    end

    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN || !gen)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast));

endmodule

// ==== verilog/item_vector_gen.sv ====
`timescale 1ns/1ps

module item_vector_gen import hdgen_pkg::*; #(
    parameter int DIM = 128
) (
    input  logic           AXIS_ACLK,
    input  logic           S_AXI_ARESETN,
    input  logic           gen,
    input  item_cnt_t      item_count,
    vec_stream_if.producer vs
);

    localparam int WORDS = DIM / 32;
    localparam int WW    = (WORDS > 1) ? $clog2(WORDS) : 1;
    localparam logic [WW-1:0] LAST_WORD = WW'(WORDS - 1);

    // word counter, slice of the vector being filled
    logic [WW-1:0]  word_idx;
    logic [DIM-1:0] fill_q;
    // index of the vector being filled
    item_cnt_t      item_idx;
    logic           all_filled;
    logic           valid_q;
    logic           last_q;
    item_cnt_t      index_q;
    logic           fill_en;
    logic           fill_done;
    word_t          rand_word;

    // seed held while gen is low
    xorshift32 u_prng (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .restart       (!gen),
        .advance       (fill_en),
        .rand_word     (rand_word)
    );

    // freeze while a finished vector is refused
    assign fill_en   = gen && !all_filled && (!valid_q || vs.ready);
    assign fill_done = fill_en && (word_idx == LAST_WORD);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            word_idx <= '0;
        end else if (fill_done) begin
            word_idx <= '0;
        end else if (fill_en) begin
            word_idx <= word_idx + 1'b1;
        end
    end

    // word 0 at the lowest bits
    always_ff @(posedge AXIS_ACLK) begin
        if (fill_en) begin
            fill_q[word_idx * 32 +: 32] <= rand_word;
        end
    end

    // ========================================================================
    // item sequencing
    // ========================================================================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            item_idx   <= '0;
            all_filled <= 1'b0;
            valid_q    <= 1'b0;
            last_q     <= 1'b0;
            index_q    <= '0;
        end else begin
            if (valid_q && vs.ready) begin
                valid_q <= 1'b0;
            end
            if (fill_done) begin
                valid_q  <= 1'b1;
                index_q  <= item_idx;
                last_q   <= (item_idx == item_count);
                item_idx <= item_idx + 1'b1;
                // stop here until gen falls and rises again
                all_filled <= (item_idx == item_count);
            end
        end
    end

    assign vs.valid = valid_q;
    assign vs.data  = fill_q;
    assign vs.last  = last_q;
    assign vs.index = index_q;

endmodule

// ==== verilog/xorshift32.sv ====
`timescale 1ns/1ps

module xorshift32 import hdgen_pkg::*; (
    input  logic  AXIS_ACLK,
    input  logic  S_AXI_ARESETN,
    input  logic  restart,
    input  logic  advance,
    output word_t rand_word
);

    word_t state_q;
    word_t step_a;
    word_t step_b;
    word_t step_c;

    // three shift-xor steps
    always_comb begin
        step_a = state_q ^ (state_q << xs_shift_a);
        step_b = step_a ^ (step_a >> xs_shift_b);
        step_c = step_b ^ (step_b << xs_shift_c);
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || restart) begin
            state_q <= xs_seed;
        end else if (advance) begin
            state_q <= step_c;
        end
    end

    // the word handed out is the next state
    assign rand_word = step_c;

    // zero is a fixed point of xorshift
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        state_q != '0);

endmodule

// ==== verilog/axil_regs.sv ====
`timescale 1ns/1ps

module axil_regs import hdgen_pkg::*; (
    input  logic       AXIS_ACLK,
    input  logic       S_AXI_ARESETN,
    input  axil_addr_t s_axi_awaddr,
    input  logic       s_axi_awvalid,
    output logic       s_axi_awready,
    input  axil_data_t s_axi_wdata,
    input  logic [3:0] s_axi_wstrb,
    input  logic       s_axi_wvalid,
    output logic       s_axi_wready,
    output logic [1:0] s_axi_bresp,
    output logic       s_axi_bvalid,
    input  logic       s_axi_bready,
    input  axil_addr_t s_axi_araddr,
    input  logic       s_axi_arvalid,
    output logic       s_axi_arready,
    output axil_data_t s_axi_rdata,
    output logic [1:0] s_axi_rresp,
    output logic       s_axi_rvalid,
    input  logic       s_axi_rready,
    output logic       gen,
    output item_cnt_t  item_count,
    input  logic       done_pulse,
    input  item_cnt_t  done_count
);

    axil_state_t state;
    axil_addr_t  wr_addr;
    axil_data_t  wr_data;
    logic [3:0]  wr_strb;
    axil_addr_t  rd_addr;
    // one cycle on entry to st_aww
    logic        wr_commit;

    // ========================================================================
    // handshake state machine
    // ========================================================================

    assign s_axi_awready = (state == st_ini) || (state == st_w);
    assign s_axi_wready  = (state == st_ini) || (state == st_aw);
    // writes win over a read offered in the same cycle
    assign s_axi_arready = (state == st_ini) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = (state == st_aww);
    assign s_axi_rvalid  = (state == st_ar2);
    assign s_axi_bresp   = 2'b00;
    assign s_axi_rresp   = 2'b00;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state     <= st_ini;
            wr_commit <= 1'b0;
        end else begin
            wr_commit <= 1'b0;
            case (state)
                st_ini: begin
                    if (s_axi_awvalid && s_axi_wvalid) begin
                        state     <= st_aww;
                        wr_commit <= 1'b1;
                    end else if (s_axi_awvalid) begin
                        state <= st_aw;
                    end else if (s_axi_wvalid) begin
                        state <= st_w;
                    end else if (s_axi_arvalid) begin
                        state <= st_ar1;
                    end
                end
                st_aw: begin
                    if (s_axi_wvalid) begin
                        state     <= st_aww;
                        wr_commit <= 1'b1;
                    end
                end
                st_w: begin
                    if (s_axi_awvalid) begin
                        state     <= st_aww;
                        wr_commit <= 1'b1;
                    end
                end
                st_aww: begin
                    if (s_axi_bready) begin
                        state <= st_ini;
                    end
                end
                st_ar1: begin
                    state <= st_ar2;
                end
                st_ar2: begin
                    if (s_axi_rready) begin
                        state <= st_ini;
                    end
                end
                default: begin
                    state <= st_ini;
                end
            endcase
        end
    end

    // address and data capture on each channel handshake
    always_ff @(posedge AXIS_ACLK) begin
        if (s_axi_awvalid && s_axi_awready) begin
            wr_addr <= s_axi_awaddr;
        end
        if (s_axi_wvalid && s_axi_wready) begin
            wr_data <= s_axi_wdata;
            wr_strb <= s_axi_wstrb;
        end
        if (s_axi_arvalid && s_axi_arready) begin
            rd_addr <= s_axi_araddr;
        end
    end

    // ========================================================================
    // registers
    // ========================================================================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen        <= 1'b0;
            item_count <= '0;
        end else begin
            // self clear once the last vector is taken
            if (done_pulse) begin
                gen <= 1'b0;
            end
            if (wr_commit) begin
                case ({wr_addr[31:2], 2'b00})
                    reg_ctrl_off: begin
                        if (wr_strb[0]) begin
                            gen <= wr_data[0];
                        end
                    end
                    reg_count_off: begin
                        if (wr_strb[0]) begin
                            item_count[7:0] <= wr_data[7:0];
                        end
                        if (wr_strb[1]) begin
                            item_count[15:8] <= wr_data[15:8];
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // read data settles in st_ar1, shown in st_ar2
    always_ff @(posedge AXIS_ACLK) begin
        if (state == st_ar1) begin
            case ({rd_addr[31:2], 2'b00})
                reg_ctrl_off:  s_axi_rdata <= axil_data_t'(gen);
                reg_count_off: s_axi_rdata <= axil_data_t'(item_count);
                reg_done_off:  s_axi_rdata <= axil_data_t'(done_count);
                default:       s_axi_rdata <= '0;
            endcase
        end
    end

    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(s_axi_bvalid && s_axi_rvalid));

    // a completion can only come from a run that is still enabled
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        done_pulse |-> gen);

endmodule

// ==== verilog/vec_stream_if.sv ====
`timescale 1ns/1ps

// finished vectors from the generator to the output buffer
interface vec_stream_if import hdgen_pkg::*; #(
    parameter int DIM = 128
) ();

    logic           valid;
    logic           ready;
    logic [DIM-1:0] data;
    logic           last;
    item_cnt_t      index;

    // data, last and index hold from valid until the transfer
    modport producer (
        output valid,
        output data,
        output last,
        output index,
        input  ready
    );

    modport consumer (
        input  valid,
        input  data,
        input  last,
        input  index,
        output ready
    );

endinterface

// ==== verilog/hdgen_pkg.sv ====
package hdgen_pkg;

    // ========================================================================
    // data widths
    // ========================================================================

    // one xorshift output word
    typedef logic [31:0] word_t;

    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // item index or count, up to 65536 items
    typedef logic [15:0] item_cnt_t;

    // ========================================================================
    // AXI-Lite slave
    // ========================================================================

    typedef enum logic [2:0] {
        st_ini,
        st_aw,
        st_w,
        st_aww,
        st_ar1,
        st_ar2
    } axil_state_t;

    // bit 0 is gen
    localparam axil_addr_t reg_ctrl_off  = 32'h0000_0000;
    // last item index N, the run yields N+1 vectors
    localparam axil_addr_t reg_count_off = 32'h0000_0004;
    // read only, vectors accepted in the current or last run
    localparam axil_addr_t reg_done_off  = 32'h0000_0008;

    // ========================================================================
    // xorshift32 constants
    // ========================================================================

    localparam word_t xs_seed    = 32'd2463534242;
    localparam int    xs_shift_a = 13;
    localparam int    xs_shift_b = 17;
    localparam int    xs_shift_c = 5;

endpackage
